// ==== hw/ocl_axil_pkg.sv ====
`default_nettype none

package ocl_axil_pkg;

   localparam int AXIL_ADDR_W = 32;
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;

   typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
   typedef logic [AXIL_DATA_W-1:0] axil_data_t;
   typedef logic [1:0]             axil_resp_t;

   localparam axil_resp_t AXIL_RESP_OKAY   = 2'd0;
   localparam axil_resp_t AXIL_RESP_SLVERR = 2'd2;

   // Host to slave
   typedef struct packed {
      axil_addr_t             awaddr;
      logic                   awvalid;
      axil_data_t             wdata;
      logic [AXIL_STRB_W-1:0] wstrb;     // Targets write whole words
      logic                   wvalid;
      axil_addr_t             araddr;
      logic                   arvalid;
      logic                   bready;
      logic                   rready;
   } axil_req_t;

   // Slave to host
   typedef struct packed {
      logic       awready;
      logic       wready;
      logic       arready;
      axil_resp_t bresp;
      logic       bvalid;
      axil_data_t rdata;
      axil_resp_t rresp;
      logic       rvalid;
   } axil_rsp_t;

endpackage

`default_nettype wire

// ==== hw/ocl_cfg_pkg.sv ====
`default_nettype none

package ocl_cfg_pkg;

   localparam int CFG_ADDR_W = 32;
   localparam int CFG_DATA_W = 32;

   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;
   typedef logic [CFG_DATA_W-1:0] cfg_data_t;
   typedef logic [7:0]            cfg_sel_t;
   typedef logic [1:0]            cfg_ofs_t;     // Word index inside a target

   typedef struct packed {
      cfg_addr_t addr;
      cfg_data_t wdata;
      logic      wr;
      logic      rd;
   } cfg_req_t;

   typedef struct packed {
      logic      ack;
      cfg_data_t rdata;
   } cfg_rsp_t;

   // ---------------------------------------------------------------------
   // Address map, 256 bytes per target
   // ---------------------------------------------------------------------
   localparam int       CFG_SEL_LSB = 8;
   localparam int       CFG_OFS_LSB = 2;
   localparam cfg_sel_t SEL_SCRATCH = 8'd0;
   localparam cfg_sel_t SEL_LFSR    = 8'd1;

   localparam cfg_data_t UNMAPPED_RDATA = 32'hbad0_bad0;

   // Test blocks
   localparam int        SCRATCH_REGS    = 4;
   localparam cfg_ofs_t  LFSR_OFS_SEED   = 2'd0;   // Byte offset 0
   localparam cfg_ofs_t  LFSR_OFS_DATA   = 2'd1;   // Byte offset 4
   localparam cfg_data_t LFSR_TAPS       = 32'h0040_0007;
   localparam cfg_data_t LFSR_RESET_SEED = 32'h0000_0001;

endpackage

`default_nettype wire

// ==== hw/cfg_scratch_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_scratch_regs (
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  ocl_cfg_pkg::cfg_req_t cfg_req,
   output ocl_cfg_pkg::cfg_rsp_t cfg_rsp
);

   import ocl_cfg_pkg::*;

   cfg_data_t scratch [SCRATCH_REGS];
   cfg_ofs_t  reg_idx;
   logic      ack_q;
   cfg_data_t rdata_q;

   assign reg_idx = cfg_req.addr[CFG_OFS_LSB +: $bits(cfg_ofs_t)];

   // Register file
   always_ff @(posedge clk)
      if (!sync_rst_n)
         scratch <= '{default: '0};
      else if (cfg_req.wr)
         scratch[reg_idx] <= cfg_req.wdata;

   always_ff @(posedge clk)
      if (cfg_req.rd)
         rdata_q <= scratch[reg_idx];

   // Ack one cycle after either pulse
   always_ff @(posedge clk)
      if (!sync_rst_n)
         ack_q <= 1'b0;
      else
         ack_q <= cfg_req.wr || cfg_req.rd;

   assign cfg_rsp.ack   = ack_q;
   assign cfg_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== hw/cfg_lfsr_tst.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_lfsr_tst (
   input  logic                  clk,
   input  logic                  sync_rst_n,
   input  ocl_cfg_pkg::cfg_req_t cfg_req,
   output ocl_cfg_pkg::cfg_rsp_t cfg_rsp
);

   import ocl_cfg_pkg::*;

   cfg_data_t lfsr_q;
   cfg_data_t lfsr_adv;
   cfg_ofs_t  ofs;
   logic      ack_s1;
   logic      ack_s2;
   cfg_data_t rdata_s1;
   cfg_data_t rdata_s2;

   // Shift left, fold taps back in when the MSB falls out
   function automatic cfg_data_t lfsr_next(input cfg_data_t cur);
      cfg_data_t shifted;
      shifted = {cur[CFG_DATA_W-2:0], 1'b0};
      return cur[CFG_DATA_W-1] ? (shifted ^ LFSR_TAPS) : shifted;
   endfunction

   assign ofs      = cfg_req.addr[CFG_OFS_LSB +: $bits(cfg_ofs_t)];
   assign lfsr_adv = lfsr_next(lfsr_q);

   always_ff @(posedge clk)
      if (!sync_rst_n)
         lfsr_q <= LFSR_RESET_SEED;
      else if (cfg_req.wr && (ofs == LFSR_OFS_SEED))
         lfsr_q <= cfg_req.wdata;    // New seed
      else if (cfg_req.rd && (ofs == LFSR_OFS_DATA))
         lfsr_q <= lfsr_adv;

   // ---------------------------------------------------------------------
   // Two-stage response pipe
   // ---------------------------------------------------------------------
   always_ff @(posedge clk)
      if (cfg_req.rd)
      begin
         case (ofs)
            LFSR_OFS_SEED:
               rdata_s1 <= lfsr_q;
            LFSR_OFS_DATA:
               rdata_s1 <= lfsr_adv;   // Value after the advance
            default:
               rdata_s1 <= '0;
         endcase
      end

   always_ff @(posedge clk)
      rdata_s2 <= rdata_s1;

   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         ack_s1 <= 1'b0;
         ack_s2 <= 1'b0;
      end
      else
      begin
         ack_s1 <= cfg_req.wr || cfg_req.rd;
         ack_s2 <= ack_s1;
      end

   assign cfg_rsp.ack   = ack_s2;
   assign cfg_rsp.rdata = rdata_s2;

endmodule

`default_nettype wire

// ==== hw/ocl_slv.sv ====
`timescale 1ns/1ps
`default_nettype none

module ocl_slv (
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  logic                    flr_assert,
   input  ocl_axil_pkg::axil_req_t axil_req,
   output ocl_axil_pkg::axil_rsp_t axil_rsp,
   output ocl_cfg_pkg::cfg_req_t   scratch_req,
   input  ocl_cfg_pkg::cfg_rsp_t   scratch_rsp,
   output ocl_cfg_pkg::cfg_req_t   lfsr_req,
   input  ocl_cfg_pkg::cfg_rsp_t   lfsr_rsp
);

   import ocl_axil_pkg::*;
   import ocl_cfg_pkg::*;

   typedef enum logic [1:0] {
      IDLE,
      WR_ADDR,
      CYC,
      RESP
   } slv_state_t;

   slv_state_t slv_state;
   slv_state_t slv_state_nxt;

   logic       cyc_wr;          // Winner of the access, 1 = write
   axil_addr_t cyc_addr;
   cfg_sel_t   cyc_sel;
   logic       scratch_hit;
   logic       lfsr_hit;
   logic       sel_hit;
   logic       req_valid;
   logic       rsp_ready;
   logic       did_req;
   logic       issue;
   logic       ack_mx;
   cfg_data_t  rdata_mx;
   logic       cyc_done;
   logic       cyc_exit;
   cfg_data_t  rdata_q;
   cfg_addr_t  req_addr_q;
   cfg_data_t  req_wdata_q;
   logic       scratch_wr_q;
   logic       scratch_rd_q;
   logic       lfsr_wr_q;
   logic       lfsr_rd_q;
   logic       awready_q;
   logic       wready_q;
   logic       arready_q;

   assign req_valid = cyc_wr ? axil_req.wvalid : 1'b1;   // Reads need no data phase
   assign rsp_ready = cyc_wr ? axil_req.bready : axil_req.rready;

   // ---------------------------------------------------------------------
   // Winner and address latch
   // ---------------------------------------------------------------------
   always_ff @(posedge clk)
      if (!sync_rst_n)
         cyc_wr <= 1'b0;
      else if (slv_state == IDLE)
         cyc_wr <= axil_req.awvalid;   // Writes have priority

   always_ff @(posedge clk)
      if ((slv_state == IDLE) && (axil_req.awvalid || axil_req.arvalid))
         cyc_addr <= axil_req.awvalid ? axil_req.awaddr : axil_req.araddr;

   assign cyc_sel     = cyc_addr[CFG_SEL_LSB +: $bits(cfg_sel_t)];
   assign scratch_hit = (cyc_sel == SEL_SCRATCH);
   assign lfsr_hit    = (cyc_sel == SEL_LFSR);
   assign sel_hit     = scratch_hit || lfsr_hit;

   // ---------------------------------------------------------------------
   // State machine
   // ---------------------------------------------------------------------
   always_comb
   begin
      slv_state_nxt = slv_state;
      if (flr_assert)
         slv_state_nxt = IDLE;
      else
      begin
         case (slv_state)
            IDLE:
            begin
               if (axil_req.awvalid)
                  slv_state_nxt = WR_ADDR;
               else if (axil_req.arvalid)
                  slv_state_nxt = CYC;
            end
            WR_ADDR:
               slv_state_nxt = CYC;
            CYC:
            begin
               if (cyc_done)
                  slv_state_nxt = RESP;
            end
            RESP:
            begin
               if (rsp_ready)
                  slv_state_nxt = IDLE;
            end
            default:
               slv_state_nxt = IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
      if (!sync_rst_n)
         slv_state <= IDLE;
      else
         slv_state <= slv_state_nxt;

   // ---------------------------------------------------------------------
   // Config bus request
   // ---------------------------------------------------------------------
   assign issue = (slv_state == CYC) && req_valid && !did_req && sel_hit && !flr_assert;

   always_ff @(posedge clk)
      if (!sync_rst_n)
         did_req <= 1'b0;
      else if (slv_state == IDLE)
         did_req <= 1'b0;
      else if (issue)
         did_req <= 1'b1;

   always_ff @(posedge clk)
      if (issue)
      begin
         req_addr_q  <= cyc_addr;
         req_wdata_q <= axil_req.wdata;
      end

   // One-cycle pulses, only to the selected target
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         scratch_wr_q <= 1'b0;
         scratch_rd_q <= 1'b0;
         lfsr_wr_q    <= 1'b0;
         lfsr_rd_q    <= 1'b0;
      end
      else
      begin
         scratch_wr_q <= issue && cyc_wr && scratch_hit;
         scratch_rd_q <= issue && !cyc_wr && scratch_hit;
         lfsr_wr_q    <= issue && cyc_wr && lfsr_hit;
         lfsr_rd_q    <= issue && !cyc_wr && lfsr_hit;
      end

   assign scratch_req.addr  = req_addr_q;
   assign scratch_req.wdata = req_wdata_q;
   assign scratch_req.wr    = scratch_wr_q;
   assign scratch_req.rd    = scratch_rd_q;

   assign lfsr_req.addr  = req_addr_q;
   assign lfsr_req.wdata = req_wdata_q;
   assign lfsr_req.wr    = lfsr_wr_q;
   assign lfsr_req.rd    = lfsr_rd_q;

   // ---------------------------------------------------------------------
   // Ack and read data combine
   // ---------------------------------------------------------------------
   always_comb
   begin
      ack_mx   = 1'b0;
      rdata_mx = UNMAPPED_RDATA;
      if (scratch_hit)
      begin
         ack_mx   = scratch_rsp.ack;
         rdata_mx = scratch_rsp.rdata;
      end
      else if (lfsr_hit)
      begin
         ack_mx   = lfsr_rsp.ack;
         rdata_mx = lfsr_rsp.rdata;
      end
   end

   // Unmapped select finishes without touching a target
   assign cyc_done = (slv_state == CYC) && (sel_hit ? (did_req && ack_mx) : req_valid);
   assign cyc_exit = (slv_state == CYC) && (slv_state_nxt == RESP);

   always_ff @(posedge clk)
      if (cyc_done)
         rdata_q <= rdata_mx;

   // ---------------------------------------------------------------------
   // AXI-Lite handshakes
   // ---------------------------------------------------------------------
   always_ff @(posedge clk)
      if (!sync_rst_n)
      begin
         awready_q <= 1'b0;
         wready_q  <= 1'b0;
         arready_q <= 1'b0;
      end
      else
      begin
         awready_q <= (slv_state_nxt == WR_ADDR);
         wready_q  <= cyc_exit && cyc_wr;
         arready_q <= cyc_exit && !cyc_wr;
      end

   assign axil_rsp.awready = awready_q;
   assign axil_rsp.wready  = wready_q;
   assign axil_rsp.arready = arready_q;

   assign axil_rsp.bvalid = (slv_state == RESP) && cyc_wr;
   assign axil_rsp.bresp  = sel_hit ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
   assign axil_rsp.rvalid = (slv_state == RESP) && !cyc_wr;
   assign axil_rsp.rresp  = sel_hit ? AXIL_RESP_OKAY : AXIL_RESP_SLVERR;
   assign axil_rsp.rdata  = rdata_q;

endmodule

`default_nettype wire

// ==== hw/ocl_cfg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ocl_cfg_top (
   input  logic                    clk,
   input  logic                    sync_rst_n,
   input  logic                    flr_assert,
   input  ocl_axil_pkg::axil_req_t axil_req,
   output ocl_axil_pkg::axil_rsp_t axil_rsp
);

   import ocl_cfg_pkg::*;

   cfg_req_t scratch_req;
   cfg_rsp_t scratch_rsp;
   cfg_req_t lfsr_req;
   cfg_rsp_t lfsr_rsp;

   // Access engine
   ocl_slv ocl_slv_inst (
      .clk         (clk),
      .sync_rst_n  (sync_rst_n),
      .flr_assert  (flr_assert),
      .axil_req    (axil_req),
      .axil_rsp    (axil_rsp),
      .scratch_req (scratch_req),
      .scratch_rsp (scratch_rsp),
      .lfsr_req    (lfsr_req),
      .lfsr_rsp    (lfsr_rsp)
   );

   // Targets
   cfg_scratch_regs cfg_scratch_regs_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_req    (scratch_req),
      .cfg_rsp    (scratch_rsp)
   );

   cfg_lfsr_tst cfg_lfsr_tst_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .cfg_req    (lfsr_req),
      .cfg_rsp    (lfsr_rsp)
   );

endmodule

`default_nettype wire

// ==== dv/ocl_cfg_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ocl_cfg_tb;

   import ocl_axil_pkg::*;
   import ocl_cfg_pkg::*;

   localparam int WAIT_LIMIT = 40;   // Cycles per handshake
   localparam int HS_AWREADY = 0;
   localparam int HS_WREADY  = 1;
   localparam int HS_ARREADY = 2;
   localparam int HS_BVALID  = 3;
   localparam int HS_RVALID  = 4;

   logic      clk;
   logic      sync_rst_n;
   logic      flr_assert;
   axil_req_t axil_req;
   axil_rsp_t axil_rsp;

   cfg_data_t scratch_model [SCRATCH_REGS];
   cfg_data_t lfsr_model;
   int        errors;
   int        tests_run;
   int        tests_failed;
   bit        timed_out;

   ocl_cfg_top ocl_cfg_top_inst (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .flr_assert (flr_assert),
      .axil_req   (axil_req),
      .axil_rsp   (axil_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic handshake_level(input int hs);
      case (hs)
         HS_AWREADY: return axil_rsp.awready;
         HS_WREADY:  return axil_rsp.wready;
         HS_ARREADY: return axil_rsp.arready;
         HS_BVALID:  return axil_rsp.bvalid;
         default:    return axil_rsp.rvalid;
      endcase
   endfunction

   function automatic string handshake_name(input int hs);
      case (hs)
         HS_AWREADY: return "awready";
         HS_WREADY:  return "wready";
         HS_ARREADY: return "arready";
         HS_BVALID:  return "bvalid";
         default:    return "rvalid";
      endcase
   endfunction

   // Sampled on the falling edge, away from the DUT's updates
   task automatic wait_for(input int hs, output bit seen);
      int cycles;
      seen = 1'b0;
      for (cycles = 0; cycles < WAIT_LIMIT && !seen; cycles++)
      begin
         @(negedge clk);
         seen = handshake_level(hs);
      end
      if (!seen)
      begin
         $display("Timeout at %0t ns: %s never came high", $time, handshake_name(hs));
         timed_out = 1'b1;
      end
   endtask

   // Response has to stay put while ready is low
   task automatic hold_off(input int hs, input axil_resp_t resp, input axil_data_t rdata);
      int idle;
      bit held;
      idle = $urandom % 4;   // Back-pressure cycles
      repeat (idle)
      begin
         @(negedge clk);
         if (hs == HS_BVALID)
            held = axil_rsp.bvalid && (axil_rsp.bresp == resp);
         else
            held = axil_rsp.rvalid && (axil_rsp.rresp == resp) && (axil_rsp.rdata == rdata);
         if (!held)
         begin
            $display("[ERROR] %0t ns: %s response not held under back-pressure",
                     $time, handshake_name(hs));
            errors++;
         end
      end
   endtask

   // Reference behavior of the register map
   task automatic model_access(input logic is_wr, input axil_addr_t addr,
                               input axil_data_t wdata, output axil_data_t rdata,
                               output axil_resp_t resp);
      logic [7:0] sel;
      logic [1:0] word;
      sel   = addr[15:8];
      word  = addr[3:2];
      rdata = '0;
      resp  = AXIL_RESP_OKAY;
      if (sel == SEL_SCRATCH)
      begin
         if (is_wr)
            scratch_model[word] = wdata;
         else
            rdata = scratch_model[word];
      end
      else if (sel == SEL_LFSR)
      begin
         if (word == 2'd0 && is_wr)
            lfsr_model = wdata;
         else if (word == 2'd0)
            rdata = lfsr_model;
         else if (word == 2'd1 && !is_wr)
         begin
            lfsr_model = (lfsr_model << 1) ^ (lfsr_model[31] ? LFSR_TAPS : 32'h0);
            rdata      = lfsr_model;
         end
      end
      else
      begin
         resp  = AXIL_RESP_SLVERR;
         rdata = is_wr ? 32'h0 : UNMAPPED_RDATA;
      end
   endtask

   task automatic do_write(input axil_addr_t addr, input axil_data_t data,
                           output axil_resp_t resp);
      bit seen;
      resp = '0;
      @(posedge clk);
      axil_req.awaddr  <= addr;
      axil_req.awvalid <= 1'b1;
      axil_req.wdata   <= data;
      axil_req.wstrb   <= 4'hf;
      axil_req.wvalid  <= 1'b1;
      wait_for(HS_AWREADY, seen);
      if (!seen)
         return;
      @(posedge clk);
      axil_req.awvalid <= 1'b0;
      wait_for(HS_WREADY, seen);
      if (!seen)
         return;
      @(posedge clk);
      axil_req.wvalid <= 1'b0;
      wait_for(HS_BVALID, seen);
      if (!seen)
         return;
      resp = axil_rsp.bresp;
      hold_off(HS_BVALID, resp, '0);
      @(posedge clk);
      axil_req.bready <= 1'b1;
      @(posedge clk);
      axil_req.bready <= 1'b0;
      @(negedge clk);
      if (axil_rsp.bvalid)
      begin
         $display("[ERROR] %0t ns: write response repeated after bready", $time);
         errors++;
      end
   endtask

   task automatic do_read(input axil_addr_t addr, output axil_data_t rdata,
                          output axil_resp_t resp);
      bit seen;
      rdata = '0;
      resp  = '0;
      @(posedge clk);
      axil_req.araddr  <= addr;
      axil_req.arvalid <= 1'b1;
      wait_for(HS_ARREADY, seen);
      if (!seen)
         return;
      @(posedge clk);
      axil_req.arvalid <= 1'b0;
      wait_for(HS_RVALID, seen);
      if (!seen)
         return;
      rdata = axil_rsp.rdata;
      resp  = axil_rsp.rresp;
      hold_off(HS_RVALID, resp, rdata);
      @(posedge clk);
      axil_req.rready <= 1'b1;
      @(posedge clk);
      axil_req.rready <= 1'b0;
      @(negedge clk);
      if (axil_rsp.rvalid)
      begin
         $display("[ERROR] %0t ns: read response repeated after rready", $time);
         errors++;
      end
   endtask

   task automatic pulse_flr();
      @(posedge clk);
      flr_assert <= 1'b1;
      @(posedge clk);
      flr_assert <= 1'b0;
      @(negedge clk);
      if (axil_rsp.bvalid || axil_rsp.rvalid)
      begin
         $display("[ERROR] %0t ns: response valid after flr", $time);
         errors++;
      end
   endtask

   // ----------------------------------------------------------------------
   // Replay of the test file
   // ----------------------------------------------------------------------
   initial
   begin
      int         fd;
      int         fields;
      int         line_no;
      int         errors_before;
      string      line;
      logic [7:0] op;
      axil_addr_t addr;
      axil_data_t wdata;
      axil_data_t file_rdata;
      axil_resp_t file_resp;
      axil_data_t exp_rdata;
      axil_resp_t exp_resp;
      axil_data_t got_rdata;
      axil_resp_t got_resp;

      void'($urandom(32'h0042_e410));
      sync_rst_n <= 1'b0;
      flr_assert <= 1'b0;
      axil_req   <= '0;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      got_rdata    = '0;
      got_resp     = '0;
      scratch_model = '{default: '0};
      lfsr_model    = LFSR_RESET_SEED;

      repeat (4) @(posedge clk);
      sync_rst_n <= 1'b1;
      @(negedge clk);
      if (axil_rsp.awready || axil_rsp.wready || axil_rsp.arready ||
          axil_rsp.bvalid || axil_rsp.rvalid)
      begin
         $display("[ERROR] %0t ns: handshake outputs high after reset", $time);
         errors++;
      end

      fd = $fopen("dv/ocl_tests.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open the test file dv/ocl_tests.txt");
         errors++;
      end

      for (line_no = 1; fd != 0 && !timed_out && line_no < 1000; line_no++)
      begin
         if ($fgets(line, fd) == 0)
            break;
         if (line.len() < 2 || line.getc(0) == "#")
            continue;
         fields = $sscanf(line, "%c %h %h %h %h", op, addr, wdata, file_rdata, file_resp);
         if (fields != 5)
         begin
            $display("Line %0d of the test file could not be parsed", line_no);
            errors++;
            continue;
         end
         tests_run++;
         errors_before = errors;
         case (op)
            "F":
               pulse_flr();
            "W", "R":
            begin
               model_access(op == "W", addr, wdata, exp_rdata, exp_resp);
               // File values must agree with the model
               if ((op == "R" && file_rdata != exp_rdata) || file_resp != exp_resp)
               begin
                  $display("[ERROR] %0t ns: file line %0d expects 0x%08h/%0d, model 0x%08h/%0d",
                           $time, line_no, file_rdata, file_resp, exp_rdata, exp_resp);
                  errors++;
               end
               if (op == "W")
                  do_write(addr, wdata, got_resp);
               else
                  do_read(addr, got_rdata, got_resp);
               if (!timed_out && got_resp != exp_resp)
               begin
                  $display("[ERROR] %0t ns: response %0d at 0x%08h, expected %0d",
                           $time, got_resp, addr, exp_resp);
                  errors++;
               end
               if (!timed_out && op == "R" && got_rdata != exp_rdata)
               begin
                  $display("[ERROR] %0t ns: read 0x%08h at 0x%08h, expected 0x%08h",
                           $time, got_rdata, addr, exp_rdata);
                  errors++;
               end
            end
            default:
            begin
               $display("Line %0d of the test file has an unknown operation", line_no);
               errors++;
            end
         endcase
         if (errors != errors_before || timed_out)
            tests_failed++;
         $display("test %0d: %c 0x%08h %s", tests_run, op, addr,
                  (errors != errors_before || timed_out) ? "FAIL" : "ok");
      end
      if (fd != 0)
         $fclose(fd);

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0 && !timed_out && tests_run > 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== build.f ====
hw/ocl_axil_pkg.sv
hw/ocl_cfg_pkg.sv
hw/cfg_scratch_regs.sv
hw/cfg_lfsr_tst.sv
hw/ocl_slv.sv
hw/ocl_cfg_top.sv
dv/ocl_cfg_tb.sv

// ==== Makefile ====
# Verilator build and run for the AXI-Lite register subsystem

SIM := obj_dir/ocl_cfg_tb_sim
LOG := sim.log

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): build.f hw/*.sv dv/ocl_cfg_tb.sv
	verilator --binary --timing --timescale 1ns/1ps --top-module ocl_cfg_tb \
		-f build.f -o ocl_cfg_tb_sim

run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q "Verification failed" $(LOG) || ! grep -q "Verification passed" $(LOG); \
	then echo "Simulation FAILED"; exit 1; else echo "Simulation PASSED"; fi

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/ocl_tests.txt ====
# op addr wdata exp_rdata exp_resp, values in hex
# op is W write, R read or F flr pulse; exp_rdata is only checked on reads
R 00000100 00000000 00000001 0
R 00000104 00000000 00000002 0
R 00000104 00000000 00000004 0
W 00000000 a5a50001 00000000 0
W 00000004 5a5a0002 00000000 0
W 00000008 c3c30003 00000000 0
W 0000000c 3c3c0004 00000000 0
R 00000000 00000000 a5a50001 0
R 00000004 00000000 5a5a0002 0
R 00000008 00000000 c3c30003 0
R 0000000c 00000000 3c3c0004 0
W 00000100 80000001 00000000 0
R 00000100 00000000 80000001 0
R 00000104 00000000 00400005 0
W 00000104 deadbeef 00000000 0
R 00000104 00000000 0080000a 0
W 00000200 11112222 00000000 2
R 00000200 00000000 bad0bad0 2
R 0000ff08 00000000 bad0bad0 2
F 00000000 00000000 00000000 0
R 00000000 00000000 a5a50001 0
W 00000008 0f0f0f0f 00000000 0
F 00000000 00000000 00000000 0
F 00000000 00000000 00000000 0
R 00000008 00000000 0f0f0f0f 0
W 00000100 c0000000 00000000 0
R 00000104 00000000 80400007 0
R 00000104 00000000 00c00009 0
R 00000100 00000000 00c00009 0
